/* addrMem.f */
common/x86CorePkg.sv
common/memBusPkg.sv
memAccess/operandLoader.sv
memAccess/resultStorer.sv
memAccess/busArbiter.sv
memAccess/accessSequencer.sv
source/addressCalc.sv
source/dataMemory.sv
source/addrMemTop.sv
verif/busArbiter_properties.sv
verif/addrMemTb.sv

/* common/memBusPkg.sv */
// Shared memory bus definitions
`default_nettype none

package memBusPkg;

	// requester slots on the arbiter, lower index wins
	localparam int NUM_REQ = 3;
	localparam int REQ_SRC1 = 0;
	localparam int REQ_SRC2 = 1;
	localparam int REQ_DEST = 2;

	localparam int MEM_WORDS = 64; // depth in 64-bit words
	localparam int MEM_IDX_BITS = $clog2(MEM_WORDS);
	localparam int WORD_OFFSET_BITS = 3; // byte offset inside a word is dropped

	typedef logic [MEM_IDX_BITS-1:0] memIdx;

endpackage

`default_nettype wire

/* common/x86CorePkg.sv */
// Core datapath widths
`default_nettype none

package x86CorePkg;

	// register values, RIP, displacements and addresses all share one width
	localparam int WORD_BITS = 64;

	localparam int LEN_BITS = 32; // instruction length and displacement length fields

	typedef logic [WORD_BITS-1:0] addrWord;

endpackage

`default_nettype wire

/* memAccess/accessSequencer.sv */
// Memory access sequencer
`default_nettype none
`timescale 1ns/1ps

module accessSequencer (
	input logic clk,
	input logic rst,
	input logic calcValidIn,
	input x86CorePkg::addrWord memoryAddressSrc1In,
	input x86CorePkg::addrWord memoryAddressSrc2In,
	input x86CorePkg::addrWord memoryAddressDestIn,
	input logic isMemoryAccessSrc1In,
	input logic isMemoryAccessSrc2In,
	input logic isMemoryAccessDestIn,
	input x86CorePkg::addrWord operand1ValIn,
	input x86CorePkg::addrWord operand2ValIn,
	input x86CorePkg::addrWord storeDataIn,
	input x86CorePkg::addrWord readDataIn,
	output x86CorePkg::addrWord memAddrOut,
	output logic memWriteOut,
	output x86CorePkg::addrWord memWriteDataOut,
	output logic busyOut,
	output logic doneOut,
	output x86CorePkg::addrWord operand1Out,
	output x86CorePkg::addrWord operand2Out,
	output x86CorePkg::addrWord memoryAddressSrc1Out,
	output x86CorePkg::addrWord memoryAddressSrc2Out,
	output x86CorePkg::addrWord memoryAddressDestOut
);
	import x86CorePkg::*;
	import memBusPkg::*;

	logic [NUM_REQ-1:0] reqVec;
	logic [NUM_REQ-1:0] grantVec;
	logic [NUM_REQ-1:0] finishedVec;
	logic [NUM_REQ-1:0] pending; // accesses still outstanding for this instruction
	logic busyR;
	logic startLoad1;
	logic startLoad2;
	logic startStore;
	logic finishNow;
	addrWord load1Addr;
	addrWord load2Addr;
	addrWord storeAddr;
	addrWord load1Data;
	addrWord load2Data;
	addrWord storeData;

	// the stage output is stable during the strobe, so starts come straight off it
	assign startLoad1 = calcValidIn && isMemoryAccessSrc1In;
	assign startLoad2 = calcValidIn && isMemoryAccessSrc2In;
	assign startStore = calcValidIn && isMemoryAccessDestIn;

	assign busyOut = calcValidIn || busyR; // covers the strobe cycle before busyR rises
	assign finishNow = busyR && !doneOut && (pending == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			busyR <= 1'b0;
			pending <= '0;
			doneOut <= 1'b0;
		end else begin
			doneOut <= finishNow;
			if (calcValidIn) begin
				busyR <= 1'b1;
				pending[REQ_SRC1] <= isMemoryAccessSrc1In;
				pending[REQ_SRC2] <= isMemoryAccessSrc2In;
				pending[REQ_DEST] <= isMemoryAccessDestIn;
			end else if (doneOut) begin
				busyR <= 1'b0; // busy drops after the done cycle
			end else begin
				pending <= pending & ~finishedVec;
			end
		end
	end

	// final operands pick loaded words only for memory sources
	always_ff @(posedge clk) begin
		if (finishNow) begin
			operand1Out <= isMemoryAccessSrc1In ? load1Data : operand1ValIn;
			operand2Out <= isMemoryAccessSrc2In ? load2Data : operand2ValIn;
			memoryAddressSrc1Out <= memoryAddressSrc1In;
			memoryAddressSrc2Out <= memoryAddressSrc2In;
			memoryAddressDestOut <= memoryAddressDestIn;
		end
	end

	operandLoader loadSrc1 (
		.clk(clk), .rst(rst), .startIn(startLoad1), .grantIn(grantVec[REQ_SRC1]),
		.addressIn(memoryAddressSrc1In), .readDataIn(readDataIn),
		.reqOut(reqVec[REQ_SRC1]), .addrOut(load1Addr), .dataOut(load1Data),
		.doneOut(finishedVec[REQ_SRC1])
	);

	operandLoader loadSrc2 (
		.clk(clk), .rst(rst), .startIn(startLoad2), .grantIn(grantVec[REQ_SRC2]),
		.addressIn(memoryAddressSrc2In), .readDataIn(readDataIn),
		.reqOut(reqVec[REQ_SRC2]), .addrOut(load2Addr), .dataOut(load2Data),
		.doneOut(finishedVec[REQ_SRC2])
	);

	resultStorer storeDest (
		.clk(clk), .rst(rst), .startIn(startStore), .grantIn(grantVec[REQ_DEST]),
		.addressIn(memoryAddressDestIn), .storeDataIn(storeDataIn),
		.reqOut(reqVec[REQ_DEST]), .addrOut(storeAddr), .writeDataOut(storeData),
		.doneOut(finishedVec[REQ_DEST])
	);

	busArbiter arb0 (
		.reqIn(reqVec), .addrSrc1In(load1Addr), .addrSrc2In(load2Addr),
		.addrDestIn(storeAddr), .writeDataIn(storeData), .grantOut(grantVec),
		.memAddrOut(memAddrOut), .memWriteOut(memWriteOut),
		.memWriteDataOut(memWriteDataOut)
	);

endmodule

`default_nettype wire

/* memAccess/busArbiter.sv */
// Fixed priority memory port arbiter
`default_nettype none
`timescale 1ns/1ps

module busArbiter (
	input logic [memBusPkg::NUM_REQ-1:0] reqIn,
	input x86CorePkg::addrWord addrSrc1In,
	input x86CorePkg::addrWord addrSrc2In,
	input x86CorePkg::addrWord addrDestIn,
	input x86CorePkg::addrWord writeDataIn,
	output logic [memBusPkg::NUM_REQ-1:0] grantOut,
	output x86CorePkg::addrWord memAddrOut,
	output logic memWriteOut,
	output x86CorePkg::addrWord memWriteDataOut
);
	import memBusPkg::*;

	// source loads win over the store so they see the old word
	always_comb begin
		grantOut = '0;
		if (reqIn[REQ_SRC1])
			grantOut[REQ_SRC1] = 1'b1;
		else if (reqIn[REQ_SRC2])
			grantOut[REQ_SRC2] = 1'b1;
		else if (reqIn[REQ_DEST])
			grantOut[REQ_DEST] = 1'b1;
	end

	always_comb begin
		if (grantOut[REQ_SRC1])
			memAddrOut = addrSrc1In;
		else if (grantOut[REQ_SRC2])
			memAddrOut = addrSrc2In;
		else if (grantOut[REQ_DEST])
			memAddrOut = addrDestIn;
		else
			memAddrOut = '0; // idle port
	end

	assign memWriteOut = grantOut[REQ_DEST]; // only the storer ever writes
	assign memWriteDataOut = writeDataIn;

endmodule

`default_nettype wire

/* memAccess/operandLoader.sv */
// Memory source operand loader
`default_nettype none
`timescale 1ns/1ps

module operandLoader (
	input logic clk,
	input logic rst,
	input logic startIn,
	input logic grantIn,
	input x86CorePkg::addrWord addressIn,
	input x86CorePkg::addrWord readDataIn,
	output logic reqOut,
	output x86CorePkg::addrWord addrOut,
	output x86CorePkg::addrWord dataOut,
	output logic doneOut
);
	import x86CorePkg::*;

	typedef enum logic [1:0] {stIdle, stWaitGrant, stCapture} loaderState;

	loaderState state;

	assign reqOut = (state == stWaitGrant); // held until the arbiter picks us

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			doneOut <= 1'b0;
		end else begin
			doneOut <= 1'b0;
			case (state)
				stIdle: if (startIn) state <= stWaitGrant;
				stWaitGrant: if (grantIn) state <= stCapture;
				stCapture: begin
					// read data from the grant cycle is on the bus now
					state <= stIdle;
					doneOut <= 1'b1;
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (startIn && state == stIdle)
			addrOut <= addressIn;
		if (state == stCapture)
			dataOut <= readDataIn; // kept until the next load
	end

endmodule

`default_nettype wire

/* memAccess/resultStorer.sv */
// Destination store requester
`default_nettype none
`timescale 1ns/1ps

module resultStorer (
	input logic clk,
	input logic rst,
	input logic startIn,
	input logic grantIn,
	input x86CorePkg::addrWord addressIn,
	input x86CorePkg::addrWord storeDataIn,
	output logic reqOut,
	output x86CorePkg::addrWord addrOut,
	output x86CorePkg::addrWord writeDataOut,
	output logic doneOut
);
	logic pending;

	assign reqOut = pending;
	assign doneOut = pending && grantIn; // the write lands at the end of the grant cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (startIn) begin
			pending <= 1'b1;
		end else if (grantIn) begin
			pending <= 1'b0;
		end
	end

	// address and data stay on the port side while the request waits
	always_ff @(posedge clk) begin
		if (startIn) begin
			addrOut <= addressIn;
			writeDataOut <= storeDataIn;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the addrMem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module addrMemTb -f addrMem.f -o addrMemSim

# the simulator exits nonzero on a failure, the log decides the result
./obj_dir/addrMemSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
grep -q "TB PASSED" sim.log

/* source/addrMemTop.sv */
// Address and memory operand top
`default_nettype none
`timescale 1ns/1ps

module addrMemTop (
	input logic clk,
	input logic rst,
	input logic issueIn,
	input x86CorePkg::addrWord currentRipIn,
	input logic [x86CorePkg::LEN_BITS-1:0] instructionLengthIn,
	input logic [x86CorePkg::LEN_BITS-1:0] dispLenIn,
	input x86CorePkg::addrWord disp64In,
	input x86CorePkg::addrWord operand1ValIn,
	input x86CorePkg::addrWord operand2ValIn,
	input x86CorePkg::addrWord destRegValueIn,
	input x86CorePkg::addrWord storeDataIn,
	input logic isMemoryAccessSrc1In,
	input logic isMemoryAccessSrc2In,
	input logic isMemoryAccessDestIn,
	input logic useRipSrc1In,
	input logic useRipSrc2In,
	input logic useRipDestIn,
	output logic busyOut,
	output logic doneOut,
	output x86CorePkg::addrWord operand1Out,
	output x86CorePkg::addrWord operand2Out,
	output x86CorePkg::addrWord memoryAddressSrc1Out,
	output x86CorePkg::addrWord memoryAddressSrc2Out,
	output x86CorePkg::addrWord memoryAddressDestOut
);
	import x86CorePkg::*;
	import memBusPkg::*;

	logic calcValid;
	logic calcIsMemSrc1;
	logic calcIsMemSrc2;
	logic calcIsMemDest;
	addrWord calcAddrSrc1;
	addrWord calcAddrSrc2;
	addrWord calcAddrDest;
	addrWord calcOperand1;
	addrWord calcOperand2;
	addrWord calcStoreData;
	addrWord memAddr;
	addrWord memWriteData;
	addrWord memReadData;
	logic memWrite;
	memIdx memIndex;

	assign memIndex = memAddr[WORD_OFFSET_BITS +: MEM_IDX_BITS]; // aligned word, wraps on depth

	addressCalc calc0 (
		.clk(clk), .rst(rst), .issueIn(issueIn), .busyIn(busyOut),
		.currentRipIn(currentRipIn), .instructionLengthIn(instructionLengthIn),
		.dispLenIn(dispLenIn), .disp64In(disp64In),
		.operand1ValIn(operand1ValIn), .operand2ValIn(operand2ValIn),
		.destRegValueIn(destRegValueIn), .storeDataIn(storeDataIn),
		.isMemoryAccessSrc1In(isMemoryAccessSrc1In), .isMemoryAccessSrc2In(isMemoryAccessSrc2In),
		.isMemoryAccessDestIn(isMemoryAccessDestIn), .useRipSrc1In(useRipSrc1In),
		.useRipSrc2In(useRipSrc2In), .useRipDestIn(useRipDestIn),
		.calcValidOut(calcValid), .memoryAddressSrc1Out(calcAddrSrc1),
		.memoryAddressSrc2Out(calcAddrSrc2), .memoryAddressDestOut(calcAddrDest),
		.isMemoryAccessSrc1Out(calcIsMemSrc1), .isMemoryAccessSrc2Out(calcIsMemSrc2),
		.isMemoryAccessDestOut(calcIsMemDest), .operand1ValOut(calcOperand1),
		.operand2ValOut(calcOperand2), .storeDataOut(calcStoreData)
	);

	accessSequencer seq0 (
		.clk(clk), .rst(rst), .calcValidIn(calcValid),
		.memoryAddressSrc1In(calcAddrSrc1), .memoryAddressSrc2In(calcAddrSrc2),
		.memoryAddressDestIn(calcAddrDest), .isMemoryAccessSrc1In(calcIsMemSrc1),
		.isMemoryAccessSrc2In(calcIsMemSrc2), .isMemoryAccessDestIn(calcIsMemDest),
		.operand1ValIn(calcOperand1), .operand2ValIn(calcOperand2),
		.storeDataIn(calcStoreData), .readDataIn(memReadData),
		.memAddrOut(memAddr), .memWriteOut(memWrite), .memWriteDataOut(memWriteData),
		.busyOut(busyOut), .doneOut(doneOut),
		.operand1Out(operand1Out), .operand2Out(operand2Out),
		.memoryAddressSrc1Out(memoryAddressSrc1Out),
		.memoryAddressSrc2Out(memoryAddressSrc2Out),
		.memoryAddressDestOut(memoryAddressDestOut)
	);

	dataMemory mem0 (
		.clk(clk), .addrIn(memIndex), .writeIn(memWrite),
		.writeDataIn(memWriteData), .readDataOut(memReadData)
	);

endmodule

`default_nettype wire

/* source/addressCalc.sv */
// Memory operand address stage
`default_nettype none
`timescale 1ns/1ps

module addressCalc (
	input logic clk,
	input logic rst,
	input logic issueIn,
	input logic busyIn,
	input x86CorePkg::addrWord currentRipIn,
	input logic [x86CorePkg::LEN_BITS-1:0] instructionLengthIn,
	input logic [x86CorePkg::LEN_BITS-1:0] dispLenIn,
	input x86CorePkg::addrWord disp64In,
	input x86CorePkg::addrWord operand1ValIn,
	input x86CorePkg::addrWord operand2ValIn,
	input x86CorePkg::addrWord destRegValueIn,
	input x86CorePkg::addrWord storeDataIn,
	input logic isMemoryAccessSrc1In,
	input logic isMemoryAccessSrc2In,
	input logic isMemoryAccessDestIn,
	input logic useRipSrc1In,
	input logic useRipSrc2In,
	input logic useRipDestIn,
	output logic calcValidOut,
	output x86CorePkg::addrWord memoryAddressSrc1Out,
	output x86CorePkg::addrWord memoryAddressSrc2Out,
	output x86CorePkg::addrWord memoryAddressDestOut,
	output logic isMemoryAccessSrc1Out,
	output logic isMemoryAccessSrc2Out,
	output logic isMemoryAccessDestOut,
	output x86CorePkg::addrWord operand1ValOut,
	output x86CorePkg::addrWord operand2ValOut,
	output x86CorePkg::addrWord storeDataOut
);
	import x86CorePkg::*;

	logic accept;
	addrWord ripTarget;
	addrWord dispOffset;

	// picks between RIP-relative, base plus displacement and plain base
	function automatic addrWord formAddress(
		input logic isMem,
		input logic useRip,
		input addrWord base,
		input addrWord ripAddr,
		input addrWord offset
	);
		if (!isMem)
			return '0; // register operands carry no address
		else if (useRip)
			return ripAddr;
		else
			return base + offset;
	endfunction

	assign accept = issueIn && !busyIn; // issues during a busy instruction are dropped

	// RIP points past the current instruction, so the length is added in
	assign ripTarget = currentRipIn + disp64In
		+ {{(WORD_BITS - LEN_BITS){1'b0}}, instructionLengthIn};
	assign dispOffset = (dispLenIn == '0) ? '0 : disp64In; // no displacement means base alone

	always_ff @(posedge clk) begin
		if (rst) begin
			calcValidOut <= 1'b0;
		end else begin
			calcValidOut <= accept;
		end
	end

	// results stay put until the next accepted issue
	always_ff @(posedge clk) begin
		if (accept) begin
			memoryAddressSrc1Out <= formAddress(isMemoryAccessSrc1In, useRipSrc1In,
				operand1ValIn, ripTarget, dispOffset);
			memoryAddressSrc2Out <= formAddress(isMemoryAccessSrc2In, useRipSrc2In,
				operand2ValIn, ripTarget, dispOffset);
			memoryAddressDestOut <= formAddress(isMemoryAccessDestIn, useRipDestIn,
				destRegValueIn, ripTarget, dispOffset);
			isMemoryAccessSrc1Out <= isMemoryAccessSrc1In;
			isMemoryAccessSrc2Out <= isMemoryAccessSrc2In;
			isMemoryAccessDestOut <= isMemoryAccessDestIn;
			operand1ValOut <= operand1ValIn;
			operand2ValOut <= operand2ValIn;
			storeDataOut <= storeDataIn;
		end
	end

endmodule

`default_nettype wire

/* source/dataMemory.sv */
// Single port data memory
`default_nettype none
`timescale 1ns/1ps

module dataMemory (
	input logic clk,
	input memBusPkg::memIdx addrIn,
	input logic writeIn,
	input x86CorePkg::addrWord writeDataIn,
	output x86CorePkg::addrWord readDataOut
);
	import x86CorePkg::*;
	import memBusPkg::*;

	addrWord storage [MEM_WORDS];

	always_ff @(posedge clk) begin
		if (writeIn)
			storage[addrIn] <= writeDataIn;
	end

	// read data shows up the cycle after the address
	always_ff @(posedge clk) begin
		readDataOut <= storage[addrIn];
	end

endmodule

`default_nettype wire

/* verif/addrMemTb.sv */
// Address and memory operand testbench
`timescale 1ns/1ps
`default_nettype none

module addrMemTb;
	import x86CorePkg::*;

	// fill 64, no access 1, random 21, RIP 3, store and load 16, old word 2, held issue 1
	localparam int NUM_INSTR = 108;
	localparam int CYCLE_LIMIT = NUM_INSTR * 10 + 100;

	logic clk = 1'b0;
	logic rst;
	logic issueIn;
	addrWord currentRipIn;
	logic [31:0] instructionLengthIn;
	logic [31:0] dispLenIn;
	addrWord disp64In;
	addrWord operand1ValIn;
	addrWord operand2ValIn;
	addrWord destRegValueIn;
	addrWord storeDataIn;
	logic isMemoryAccessSrc1In;
	logic isMemoryAccessSrc2In;
	logic isMemoryAccessDestIn;
	logic useRipSrc1In;
	logic useRipSrc2In;
	logic useRipDestIn;
	logic busyOut;
	logic doneOut;
	addrWord operand1Out;
	addrWord operand2Out;
	addrWord memoryAddressSrc1Out;
	addrWord memoryAddressSrc2Out;
	addrWord memoryAddressDestOut;

	integer seed;
	int cycleCount = 0;
	int issuedCount = 0;
	int doneCount = 0;
	addrWord shadow [64]; // mirror of the data memory after every issued store
	addrWord expOp1 [$];
	addrWord expOp2 [$];
	addrWord expAddr1 [$];
	addrWord expAddr2 [$];
	addrWord expAddrDest [$];

	// fields of the next instruction, bit 0 of the flags is src1, bit 2 is dest
	addrWord nRip;
	addrWord nDisp;
	addrWord nOp1;
	addrWord nOp2;
	addrWord nDest;
	addrWord nStore;
	logic [31:0] nLen;
	logic [31:0] nDispLen;
	logic [2:0] nIsMem;
	logic [2:0] nUseRip;

	addrMemTop dut0 (
		.clk(clk), .rst(rst), .issueIn(issueIn), .currentRipIn(currentRipIn),
		.instructionLengthIn(instructionLengthIn), .dispLenIn(dispLenIn),
		.disp64In(disp64In), .operand1ValIn(operand1ValIn), .operand2ValIn(operand2ValIn),
		.destRegValueIn(destRegValueIn), .storeDataIn(storeDataIn),
		.isMemoryAccessSrc1In(isMemoryAccessSrc1In), .isMemoryAccessSrc2In(isMemoryAccessSrc2In),
		.isMemoryAccessDestIn(isMemoryAccessDestIn), .useRipSrc1In(useRipSrc1In),
		.useRipSrc2In(useRipSrc2In), .useRipDestIn(useRipDestIn),
		.busyOut(busyOut), .doneOut(doneOut), .operand1Out(operand1Out),
		.operand2Out(operand2Out), .memoryAddressSrc1Out(memoryAddressSrc1Out),
		.memoryAddressSrc2Out(memoryAddressSrc2Out),
		.memoryAddressDestOut(memoryAddressDestOut)
	);

	always #10 clk = ~clk;

	function automatic addrWord rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic [5:0] wordIndex(input addrWord addr);
		return addr[8:3]; // low three bits ignored, wraps every 64 words
	endfunction

	function automatic addrWord fillWord(input addrWord addr);
		return (addr * 64'h9E37_79B9_7F4A_7C15) ^ 64'h5A5A_0000_F00D_0000;
	endfunction

	// expected address of one operand of the next instruction
	function automatic addrWord refAddress(input logic isMem, input logic useRip,
		input addrWord base);
		if (!isMem)
			return '0;
		else if (useRip)
			return nRip + nDisp + {32'd0, nLen};
		else if (nDispLen == 32'd0)
			return base;
		else
			return base + nDisp;
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input addrWord got, input addrWord exp);
		if (got !== exp)
			failRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic clearInstr();
		nRip = '0;
		nDisp = '0;
		nOp1 = '0;
		nOp2 = '0;
		nDest = '0;
		nStore = '0;
		nLen = 32'd0;
		nDispLen = 32'd0;
		nIsMem = 3'b000;
		nUseRip = 3'b000;
	endtask

	task automatic randomInstr();
		logic [31:0] rnd;
		rnd = $random(seed);
		nRip = rand64();
		nLen = {28'd0, rnd[3:0]} + 32'd1;
		case (rnd[5:4])
			2'd0: nDispLen = 32'd0;
			2'd1: nDispLen = 32'd1;
			2'd2: nDispLen = 32'd4;
			default: nDispLen = 32'd8;
		endcase
		nDisp = rand64();
		nOp1 = rand64();
		nOp2 = rand64();
		nDest = rand64();
		nStore = rand64();
		nIsMem = rnd[8:6];
		nUseRip = 3'b000;
	endtask

	// records what the instruction should return, then drives it and waits for its done
	task automatic issueInstr(input int holdCycles);
		addrWord a1;
		addrWord a2;
		addrWord aD;
		a1 = refAddress(nIsMem[0], nUseRip[0], nOp1);
		a2 = refAddress(nIsMem[1], nUseRip[1], nOp2);
		aD = refAddress(nIsMem[2], nUseRip[2], nDest);
		expAddr1.push_back(a1);
		expAddr2.push_back(a2);
		expAddrDest.push_back(aD);
		expOp1.push_back(nIsMem[0] ? shadow[wordIndex(a1)] : nOp1);
		expOp2.push_back(nIsMem[1] ? shadow[wordIndex(a2)] : nOp2);
		if (nIsMem[2])
			shadow[wordIndex(aD)] = nStore; // loads above still saw the old word
		@(posedge clk);
		issueIn <= 1'b1;
		currentRipIn <= nRip;
		instructionLengthIn <= nLen;
		dispLenIn <= nDispLen;
		disp64In <= nDisp;
		operand1ValIn <= nOp1;
		operand2ValIn <= nOp2;
		destRegValueIn <= nDest;
		storeDataIn <= nStore;
		{isMemoryAccessDestIn, isMemoryAccessSrc2In, isMemoryAccessSrc1In} <= nIsMem;
		{useRipDestIn, useRipSrc2In, useRipSrc1In} <= nUseRip;
		@(posedge clk); // accepted here since the previous instruction is done
		for (int i = 0; i < holdCycles; i++) begin
			@(posedge clk);
			disp64In <= rand64(); // busy, so none of this may be taken
			operand1ValIn <= rand64();
			storeDataIn <= rand64();
		end
		issueIn <= 1'b0;
		issuedCount++;
		wait (doneCount == issuedCount);
	endtask

	// compares every done against the oldest outstanding instruction
	always @(posedge clk) begin
		if (!rst && doneOut) begin
			if (expOp1.size() == 0) begin
				failRun("doneOut pulsed with no instruction outstanding");
			end else begin
				checkValue("operand1Out", operand1Out, expOp1.pop_front());
				checkValue("operand2Out", operand2Out, expOp2.pop_front());
				checkValue("memoryAddressSrc1Out", memoryAddressSrc1Out, expAddr1.pop_front());
				checkValue("memoryAddressSrc2Out", memoryAddressSrc2Out, expAddr2.pop_front());
				checkValue("memoryAddressDestOut", memoryAddressDestOut,
					expAddrDest.pop_front());
				doneCount++;
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT)
			failRun($sformatf("Timeout: doneOut never arrived within %0d cycles", CYCLE_LIMIT));
	end

	initial begin
		seed = 7;
		rst = 1'b1;
		issueIn = 1'b0;
		currentRipIn = '0;
		instructionLengthIn = 32'd0;
		dispLenIn = 32'd0;
		disp64In = '0;
		operand1ValIn = '0;
		operand2ValIn = '0;
		destRegValueIn = '0;
		storeDataIn = '0;
		isMemoryAccessSrc1In = 1'b0;
		isMemoryAccessSrc2In = 1'b0;
		isMemoryAccessDestIn = 1'b0;
		useRipSrc1In = 1'b0;
		useRipSrc2In = 1'b0;
		useRipDestIn = 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		checkValue("busyOut", {63'd0, busyOut}, '0);
		checkValue("doneOut", {63'd0, doneOut}, '0);

		clearInstr(); // register operands only
		nOp1 = rand64();
		nOp2 = rand64();
		issueInstr(0);

		for (int i = 0; i < 64; i++) begin
			clearInstr(); // give every word a known value before any load
			nIsMem = 3'b100;
			nDest = 64'(i) << 3;
			nStore = fillWord(nDest);
			issueInstr(0);
		end

		for (int i = 0; i < 20; i++) begin
			randomInstr();
			issueInstr(0);
		end
		clearInstr();
		nIsMem = 3'b001;
		nOp1 = 64'hFFFF_FFFF_FFFF_FFF8;
		nDispLen = 32'd1;
		nDisp = 64'h20; // sum wraps to 0x18
		issueInstr(0);

		for (int k = 0; k < 3; k++) begin
			randomInstr();
			nIsMem = 3'b001 << k;
			nUseRip = 3'b001 << k;
			issueInstr(0);
		end

		// stores through aliased addresses, then loads of the same words
		for (int i = 0; i < 8; i++) begin
			clearInstr();
			nIsMem = 3'b100;
			nDest = (64'(i) << 3) + (64'(i + 1) << 9);
			nDispLen = 32'd4;
			nDisp = 64'h1000;
			nStore = rand64();
			issueInstr(0);
		end
		for (int i = 0; i < 8; i++) begin
			clearInstr();
			nIsMem = 3'b011;
			nOp1 = 64'(i) << 3;
			nOp2 = (64'(i) << 3) - 64'h200; // wraps below zero
			issueInstr(0);
		end

		clearInstr();
		nIsMem = 3'b111;
		nOp1 = 64'h140;
		nOp2 = 64'h140;
		nDest = 64'h140;
		nStore = rand64();
		issueInstr(0);
		clearInstr();
		nIsMem = 3'b001;
		nOp1 = 64'h140;
		issueInstr(0);

		randomInstr();
		nIsMem = 3'b111;
		issueInstr(3);
		repeat (10) @(posedge clk); // a wrongly accepted issue would show up as an extra done
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/busArbiter_properties.sv */
// Arbiter grant checks
`timescale 1ns/1ps
`default_nettype none

module busArbiterProperties (
	input logic clk,
	input logic rst,
	input logic [memBusPkg::NUM_REQ-1:0] reqIn,
	input logic [memBusPkg::NUM_REQ-1:0] grantOut
);
	import memBusPkg::*;

	oneGrant: assert property (@(posedge clk) disable iff (rst) $onehot0(grantOut))
		else $error("more than one grant bit is high");

	// a grant never appears without its request
	grantNeedsReq: assert property (@(posedge clk) disable iff (rst)
		(grantOut & ~reqIn) == '0)
		else $error("grant given to an idle requester");

	for (genvar i = 0; i < NUM_REQ; i++) begin : holdChecks
		reqHeld: assert property (@(posedge clk) disable iff (rst)
			reqIn[i] && !grantOut[i] |=> reqIn[i])
			else $error("request %0d dropped before its grant", i);
	end

endmodule

// the arbiter is combinational, so the checks sit in the sequencer that clocks it
bind accessSequencer busArbiterProperties arbProps0 (
	.clk(clk), .rst(rst), .reqIn(reqVec), .grantOut(grantVec)
);

`default_nettype wire
